// File: Bender.yml
package:
  name: residual_coder

sources:
  - include_dirs:
      - design
    files:
      - design/vp8_resid_pkg.sv
      - design/fdct4x4.sv
      - design/quant_table.sv
      - design/quant_block.sv
      - design/zigzag_nz.sv
      - design/residual_coder.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/residual_coder_chk.sv
      - test/residual_coder_tb.sv

// File: design/fdct4x4.sv
// Forward 4x4 integer transform, registered row pass followed by registered column pass
`timescale 1ns/1ps
`include "vp8_settings.svh"

module fdct4x4 (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid_i,
    input  vp8_resid_pkg::resid_blk_t resid_i,
    output logic                      out_valid_o,
    output vp8_resid_pkg::coeff_blk_t coeff_o
);
    import vp8_resid_pkg::*;

    coeff_blk_t row_d;
    coeff_blk_t row_q;
    logic       row_valid_q;
    coeff_blk_t col_d;

    // ----------------------------------------
    // Row pass
    // ----------------------------------------
    for (genvar r = 0; r < `VP8_BLK_DIM; r++) begin : g_row
        localparam int b = r * `VP8_BLK_DIM;

        logic signed [31:0] a0;
        logic signed [31:0] a1;
        logic signed [31:0] a2;
        logic signed [31:0] a3;

        // Outer and inner pair sums and differences
        assign a0 = $signed(resid_i[b])   + $signed(resid_i[b+3]);
        assign a1 = $signed(resid_i[b+1]) + $signed(resid_i[b+2]);
        assign a2 = $signed(resid_i[b+1]) - $signed(resid_i[b+2]);
        assign a3 = $signed(resid_i[b])   - $signed(resid_i[b+3]);

        // Even terms scaled by 8, odd terms rotated and rounded
        assign row_d[b]   = coeff_t'((a0 + a1) * 8);
        assign row_d[b+1] = coeff_t'((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
        assign row_d[b+2] = coeff_t'((a0 - a1) * 8);
        assign row_d[b+3] = coeff_t'((a3 * 2217 - a2 * 5352 + 937) >>> 9);
    end

    // ----------------------------------------
    // Column pass
    // ----------------------------------------
    for (genvar c = 0; c < `VP8_BLK_DIM; c++) begin : g_col
        localparam int s = `VP8_BLK_DIM;

        logic signed [31:0] a0;
        logic signed [31:0] a1;
        logic signed [31:0] a2;
        logic signed [31:0] a3;
        logic signed [31:0] odd_lo;

        assign a0 = $signed(row_q[c])   + $signed(row_q[c+3*s]);
        assign a1 = $signed(row_q[c+s]) + $signed(row_q[c+2*s]);
        assign a2 = $signed(row_q[c+s]) - $signed(row_q[c+2*s]);
        assign a3 = $signed(row_q[c])   - $signed(row_q[c+3*s]);

        assign odd_lo = (a2 * 2217 + a3 * 5352 + 12000) >>> 16;

        assign col_d[c]     = coeff_t'((a0 + a1 + 7) >>> 4);
        // Nudge up by one whenever the odd difference is nonzero
        assign col_d[c+s]   = coeff_t'(odd_lo + ((a3 != 0) ? 32'sd1 : 32'sd0));
        assign col_d[c+2*s] = coeff_t'((a0 - a1 + 7) >>> 4);
        assign col_d[c+3*s] = coeff_t'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
    end

    // ----------------------------------------
    // Pass registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid_q <= 1'b0;
            row_q       <= '0;
            out_valid_o <= 1'b0;
            coeff_o     <= '0;
        end else begin
            row_valid_q <= in_valid_i;
            row_q       <= row_d;
            out_valid_o <= row_valid_q;
            coeff_o     <= col_d;
        end
    end

endmodule

// File: design/quant_block.sv
// Two-stage per-coefficient quantizer producing levels and dequantized coefficients
`timescale 1ns/1ps
`include "vp8_settings.svh"

module quant_block (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid_i,
    input  vp8_resid_pkg::coeff_blk_t coeff_i,
    input  vp8_resid_pkg::quant_blk_t qblk_i,
    output logic                      out_valid_o,
    output vp8_resid_pkg::quant_res_t res_o
);
    import vp8_resid_pkg::*;

    // Stage 1 next values and registers
    logic [`VP8_NCOEF-1:0][31:0] lvl_d;
    logic [`VP8_NCOEF-1:0]       sgn_d;
    logic [`VP8_NCOEF-1:0]       keep_d;
    logic [`VP8_NCOEF-1:0][31:0] lvl_q;
    logic [`VP8_NCOEF-1:0]       sgn_q;
    logic [`VP8_NCOEF-1:0]       keep_q;
    logic                        v1_q;

    quant_res_t res_d;

    // ----------------------------------------
    // Stage 1: magnitude, reciprocal multiply
    // ----------------------------------------
    for (genvar p = 0; p < `VP8_NCOEF; p++) begin : g_lvl
        logic signed [31:0] cin;
        logic        [31:0] mag;
        logic        [31:0] sharp;
        logic        [63:0] scaled;

        assign cin    = $signed(coeff_i[p]);
        assign mag    = cin[31] ? -cin : cin;
        assign sharp  = mag + {16'd0, qblk_i[p].sharpen};
        assign scaled = sharp * qblk_i[p].iq + {32'd0, qblk_i[p].bias};

        assign sgn_d[p]  = cin[31];
        assign lvl_d[p]  = scaled[`VP8_QFIX +: 32];
        // Dead zone, sharpened magnitude must exceed the threshold
        assign keep_d[p] = sharp > qblk_i[p].zthresh;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q   <= 1'b0;
            lvl_q  <= '0;
            sgn_q  <= '0;
            keep_q <= '0;
        end else begin
            v1_q   <= in_valid_i;
            lvl_q  <= lvl_d;
            sgn_q  <= sgn_d;
            keep_q <= keep_d;
        end
    end

    // ----------------------------------------
    // Stage 2: clamp, sign, dequantize
    // ----------------------------------------
    for (genvar p = 0; p < `VP8_NCOEF; p++) begin : g_out
        logic        [31:0] lvl_c;
        logic signed [31:0] lvl_s;
        logic signed [31:0] dq_w;

        assign lvl_c = (lvl_q[p] > `VP8_MAX_LEVEL) ? 32'(`VP8_MAX_LEVEL) : lvl_q[p];
        assign lvl_s = sgn_q[p] ? -$signed(lvl_c) : $signed(lvl_c);
        // Step size is unsigned, keep the product signed
        assign dq_w  = lvl_s * $signed({16'd0, qblk_i[p].q});

        assign res_d.level[p] = keep_q[p] ? level_t'(lvl_s) : '0;
        assign res_d.dq[p]    = keep_q[p] ? coeff_t'(dq_w) : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
            res_o       <= '0;
        end else begin
            out_valid_o <= v1_q;
            res_o       <= res_d;
        end
    end

endmodule

// File: design/quant_table.sv
// DC and AC quantizer register sets fanned out to one parameter set per coefficient
`timescale 1ns/1ps
`include "vp8_settings.svh"

module quant_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_we_i,
    input  logic                      cfg_ac_i,
    input  vp8_resid_pkg::quant_set_t cfg_set_i,
    output vp8_resid_pkg::quant_blk_t qblk_o
);
    import vp8_resid_pkg::*;

    quant_set_t dc_q;
    quant_set_t ac_q;

    // ----------------------------------------
    // Configuration registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_q <= '0;
            ac_q <= '0;
        end else if (cfg_we_i) begin
            if (cfg_ac_i) begin
                ac_q <= cfg_set_i;
            end else begin
                dc_q <= cfg_set_i;
            end
        end
    end

    // ----------------------------------------
    // Per position expansion
    // ----------------------------------------
    // Raster 0 is the DC coefficient, everything else uses the AC set
    always_comb begin
        qblk_o    = {`VP8_NCOEF{ac_q}};
        qblk_o[0] = dc_q;
    end

endmodule

// File: design/residual_coder.sv
// Top level of the 4x4 residual path: transform, quantizer table, quantizer, zigzag
`timescale 1ns/1ps

module residual_coder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid_i,
    input  vp8_resid_pkg::resid_blk_t resid_i,
    input  logic                      cfg_we_i,
    input  logic                      cfg_ac_i,
    input  vp8_resid_pkg::quant_set_t cfg_set_i,
    output logic                      out_valid_o,
    output vp8_resid_pkg::level_blk_t levels_o,
    output vp8_resid_pkg::coeff_blk_t dq_o,
    output logic                      nz_o
);
    import vp8_resid_pkg::*;

    logic       coeff_valid;
    coeff_blk_t coeff_blk;
    quant_blk_t qblk;
    logic       qres_valid;
    quant_res_t qres;

    // ----------------------------------------
    // Pipeline stages
    // ----------------------------------------
    fdct4x4 fdct4x4_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .resid_i    (resid_i),
        .out_valid_o(coeff_valid),
        .coeff_o    (coeff_blk)
    );

    quant_table quant_table_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_we_i (cfg_we_i),
        .cfg_ac_i (cfg_ac_i),
        .cfg_set_i(cfg_set_i),
        .qblk_o   (qblk)
    );

    quant_block quant_block_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (coeff_valid),
        .coeff_i    (coeff_blk),
        .qblk_i     (qblk),
        .out_valid_o(qres_valid),
        .res_o      (qres)
    );

    zigzag_nz zigzag_nz_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (qres_valid),
        .res_i      (qres),
        .out_valid_o(out_valid_o),
        .levels_o   (levels_o),
        .dq_o       (dq_o),
        .nz_o       (nz_o)
    );

endmodule

// File: design/vp8_resid_pkg.sv
// Scalar typedefs, block arrays and quantizer structs for the residual pipeline
`include "vp8_settings.svh"

package vp8_resid_pkg;

    // ----------------------------------------
    // Scalars
    // ----------------------------------------
    typedef logic signed [`VP8_RESID_W-1:0] resid_t;
    typedef logic signed [`VP8_COEFF_W-1:0] coeff_t;
    typedef logic signed [`VP8_LEVEL_W-1:0] level_t;

    // Step size, reciprocal and sharpen share one width
    typedef logic [`VP8_QSTEP_W-1:0] qstep_t;
    // Bias and zero threshold
    typedef logic [`VP8_QWIDE_W-1:0] qwide_t;

    // ----------------------------------------
    // Whole 4x4 blocks, element 0 is raster 0
    // ----------------------------------------
    typedef resid_t [`VP8_NCOEF-1:0] resid_blk_t;
    typedef coeff_t [`VP8_NCOEF-1:0] coeff_blk_t;
    typedef level_t [`VP8_NCOEF-1:0] level_blk_t;

    // One quantizer class (DC or AC)
    typedef struct packed {
        qstep_t q;
        qstep_t iq;
        qwide_t bias;
        qwide_t zthresh;
        qstep_t sharpen;
    } quant_set_t;

    // Per raster position parameters
    typedef quant_set_t [`VP8_NCOEF-1:0] quant_blk_t;

    // Quantizer result, both halves in raster order
    typedef struct packed {
        level_blk_t level;
        coeff_blk_t dq;
    } quant_res_t;

endpackage

// File: design/vp8_settings.svh
// Block geometry, quantizer fixed-point and clamp constants, datapath field widths
`ifndef VP8_SETTINGS_SVH
`define VP8_SETTINGS_SVH

// ----------------------------------------
// Block geometry
// ----------------------------------------
`define VP8_BLK_DIM    4
`define VP8_NCOEF      16

// ----------------------------------------
// Quantizer arithmetic
// ----------------------------------------
// Shift after the reciprocal multiply
`define VP8_QFIX       17
`define VP8_MAX_LEVEL  2047

// Strobe to result, transform 2 + quantizer 2 + zigzag 1
`define VP8_PIPE_LAT   5

// ----------------------------------------
// Field widths
// ----------------------------------------
`define VP8_RESID_W    9
`define VP8_COEFF_W    16
`define VP8_LEVEL_W    16
`define VP8_QSTEP_W    16
`define VP8_QWIDE_W    32

`endif

// File: design/zigzag_nz.sv
// Output stage with zigzag level reorder, dequantized pass-through and nonzero flag
`timescale 1ns/1ps
`include "vp8_settings.svh"

module zigzag_nz (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid_i,
    input  vp8_resid_pkg::quant_res_t res_i,
    output logic                      out_valid_o,
    output vp8_resid_pkg::level_blk_t levels_o,
    output vp8_resid_pkg::coeff_blk_t dq_o,
    output logic                      nz_o
);
    import vp8_resid_pkg::*;

    // Raster index feeding each zigzag slot
    localparam int zz_idx [`VP8_NCOEF] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    level_blk_t zz_d;

    always_comb begin
        for (int k = 0; k < `VP8_NCOEF; k++) begin
            zz_d[k] = res_i.level[zz_idx[k]];
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
            levels_o    <= '0;
            dq_o        <= '0;
            nz_o        <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
            levels_o    <= zz_d;
            dq_o        <= res_i.dq;
            // Any set bit means some level is nonzero
            nz_o        <= |res_i.level;
        end
    end

endmodule

// File: sources.f
+incdir+design
design/vp8_resid_pkg.sv
design/fdct4x4.sv
design/quant_table.sv
design/quant_block.sv
design/zigzag_nz.sv
design/residual_coder.sv
test/residual_coder_chk.sv
test/residual_coder_tb.sv

// File: test/residual_coder_chk.sv
// Bound assertions on residual_coder latency, nonzero flag, level range and reset
`timescale 1ns/1ps
`include "vp8_settings.svh"

module residual_coder_chk (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid_i,
    input logic                      out_valid_o,
    input vp8_resid_pkg::level_blk_t levels_o,
    input logic                      nz_o
);
    import vp8_resid_pkg::*;

    logic        in_range;
    // Number of failed properties so far
    int unsigned err_cnt = 0;

    // All levels inside the clamp
    always_comb begin
        in_range = 1'b1;
        for (int k = 0; k < `VP8_NCOEF; k++) begin
            if ($signed(levels_o[k]) > `VP8_MAX_LEVEL ||
                $signed(levels_o[k]) < -`VP8_MAX_LEVEL) begin
                in_range = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid_i |-> ##`VP8_PIPE_LAT out_valid_o)
        else begin
            $error("out_valid_o missing %0d cycles after in_valid_i", `VP8_PIPE_LAT);
            err_cnt = err_cnt + 1;
        end

    a_lat_back: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> $past(in_valid_i, `VP8_PIPE_LAT))
        else begin
            $error("out_valid_o without a matching input strobe");
            err_cnt = err_cnt + 1;
        end

    a_nz: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> (nz_o == (|levels_o)))
        else begin
            $error("nz_o disagrees with the levels");
            err_cnt = err_cnt + 1;
        end

    a_range: assert property (@(posedge clk) disable iff (!rst_n) in_range)
        else begin
            $error("level magnitude above the clamp");
            err_cnt = err_cnt + 1;
        end

    a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid_o)
        else begin
            $error("out_valid_o high during reset");
            err_cnt = err_cnt + 1;
        end

endmodule

bind residual_coder residual_coder_chk residual_coder_chk_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .out_valid_o(out_valid_o),
    .levels_o   (levels_o),
    .nz_o       (nz_o)
);

// File: test/residual_coder_tb.sv
// Table-driven testbench for residual_coder with reference model, checker task and watchdog
`timescale 1ns/1ps

module residual_coder_tb;
    import vp8_resid_pkg::*;

    typedef enum {kind_zero, kind_dc, kind_rand, kind_small, kind_same, kind_sat} kind_e;

    typedef struct {
        kind_e      kind;
        logic       chain;
        quant_set_t dc;
        quant_set_t ac;
        resid_blk_t resid;
    } case_t;

    typedef struct {
        level_blk_t levels;
        coeff_blk_t dq;
        logic       nz;
    } expect_t;

    localparam int n_case  = 12;
    localparam int latency = 5;
    localparam int zz_order [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    // Fields are q, iq, bias, zthresh, sharpen
    localparam quant_set_t dc_real  = '{16'd20, 16'd6553, 32'd49152, 32'd12, 16'd0};
    localparam quant_set_t ac_real  = '{16'd24, 16'd5461, 32'd56320, 32'd13, 16'd0};
    // Dead zone wider than the rounding boundary, so small levels are zeroed
    localparam quant_set_t ac_dead  = '{16'd24, 16'd5461, 32'd56320, 32'd24, 16'd0};
    localparam quant_set_t ac_sharp = '{16'd24, 16'd5461, 32'd56320, 32'd24, 16'd8};
    localparam quant_set_t dc_fine  = '{16'd8, 16'd16384, 32'd49152, 32'd4, 16'd0};
    localparam quant_set_t ac_fine  = '{16'd10, 16'd13107, 32'd56320, 32'd5, 16'd2};
    // Sharpen alone lifts every level to the clamp
    localparam quant_set_t sat_set  = '{16'd8, 16'd65535, 32'd0, 32'd0, 16'd4096};

    logic       clk;
    logic       rst_n;
    logic       in_valid_i;
    resid_blk_t resid_i;
    logic       cfg_we_i;
    logic       cfg_ac_i;
    quant_set_t cfg_set_i;
    logic       out_valid_o;
    level_blk_t levels_o;
    coeff_blk_t dq_o;
    logic       nz_o;

    case_t      cases [n_case];
    expect_t    exp_q [$];
    longint     stamp_q [$];
    longint     cyc = 0;

    residual_coder residual_coder_inst (.*);

    always #5 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic coeff_blk_t forward_transform(resid_blk_t r);
        int         t [16];
        int         a0, a1, a2, a3, odd;
        coeff_blk_t c;
        for (int i = 0; i < 4; i++) begin
            a0 = $signed(r[4*i])   + $signed(r[4*i+3]);
            a1 = $signed(r[4*i+1]) + $signed(r[4*i+2]);
            a2 = $signed(r[4*i+1]) - $signed(r[4*i+2]);
            a3 = $signed(r[4*i])   - $signed(r[4*i+3]);
            t[4*i]   = (a0 + a1) * 8;
            t[4*i+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
            t[4*i+2] = (a0 - a1) * 8;
            t[4*i+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
        end
        for (int j = 0; j < 4; j++) begin
            a0 = t[j] + t[12+j];
            a1 = t[4+j] + t[8+j];
            a2 = t[4+j] - t[8+j];
            a3 = t[j] - t[12+j];
            odd = (a2 * 2217 + a3 * 5352 + 12000) >>> 16;
            if (a3 != 0)
                odd = odd + 1;
            c[j]    = coeff_t'((a0 + a1 + 7) >>> 4);
            c[4+j]  = coeff_t'(odd);
            c[8+j]  = coeff_t'((a0 - a1 + 7) >>> 4);
            c[12+j] = coeff_t'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
        return c;
    endfunction

    function automatic expect_t model_block(resid_blk_t r, quant_set_t dc, quant_set_t ac);
        coeff_blk_t c;
        quant_set_t s;
        longint     v;
        longint     sharp;
        longint     lvl;
        level_blk_t raster;
        expect_t    e;
        c      = forward_transform(r);
        raster = '0;
        e.dq   = '0;
        e.nz   = 1'b0;
        for (int p = 0; p < 16; p++) begin
            s     = (p == 0) ? dc : ac;
            v     = $signed(c[p]);
            sharp = ((v < 0) ? -v : v) + longint'(s.sharpen);
            lvl   = (sharp * longint'(s.iq) + longint'(s.bias)) >>> 17;
            if (lvl > 2047)
                lvl = 2047;
            if (v < 0)
                lvl = -lvl;
            // Dead zone on the sharpened magnitude
            if (sharp > longint'(s.zthresh)) begin
                raster[p] = level_t'(lvl);
                e.dq[p]   = coeff_t'(lvl * longint'(s.q));
            end
        end
        for (int k = 0; k < 16; k++) begin
            e.levels[k] = raster[zz_order[k]];
            if (raster[k] != 0)
                e.nz = 1'b1;
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input logic signed [63:0] got,
                                 input logic signed [63:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, want);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic write_set(input logic is_ac, input quant_set_t s);
        @(posedge clk);
        cfg_we_i  <= 1'b1;
        cfg_ac_i  <= is_ac;
        cfg_set_i <= s;
        @(posedge clk);
        cfg_we_i  <= 1'b0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid_i = 1'b0;
        resid_i    = '0;
        cfg_we_i   = 1'b0;
        cfg_ac_i   = 1'b0;
        cfg_set_i  = '0;
        void'($urandom(32'h3f58));
        // kind, chained to previous, DC set, AC set, residuals
        cases[0]  = '{kind_zero,  1'b0, dc_real, ac_real,  '0};
        cases[1]  = '{kind_dc,    1'b0, dc_real, ac_real,  '0};
        cases[2]  = '{kind_rand,  1'b0, dc_real, ac_real,  '0};
        cases[3]  = '{kind_rand,  1'b0, dc_fine, ac_fine,  '0};
        cases[4]  = '{kind_small, 1'b0, dc_real, ac_dead,  '0};
        cases[5]  = '{kind_same,  1'b0, dc_real, ac_sharp, '0};
        cases[6]  = '{kind_sat,   1'b0, sat_set, sat_set,  '0};
        cases[7]  = '{kind_rand,  1'b0, dc_real, ac_real,  '0};
        cases[8]  = '{kind_rand,  1'b1, dc_real, ac_real,  '0};
        cases[9]  = '{kind_rand,  1'b1, dc_real, ac_real,  '0};
        cases[10] = '{kind_rand,  1'b1, dc_real, ac_real,  '0};
        cases[11] = '{kind_rand,  1'b1, dc_real, ac_real,  '0};
        for (int i = 0; i < n_case; i++) begin
            for (int k = 0; k < 16; k++) begin
                case (cases[i].kind)
                    kind_zero:  cases[i].resid[k] = '0;
                    kind_dc:    cases[i].resid[k] = resid_t'(-37);
                    kind_small: cases[i].resid[k] = resid_t'(int'($urandom_range(24)) - 12);
                    kind_same:  cases[i].resid[k] = cases[i-1].resid[k];
                    default:    cases[i].resid[k] = resid_t'(int'($urandom_range(510)) - 255);
                endcase
            end
        end

        // Reset spans three rising edges, checked between them
        repeat (2) begin
            @(negedge clk);
            compare_value("out_valid_o", out_valid_o, 0);
        end
        @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_case; i++) begin
            // Reconfigure only with the pipeline drained
            if (!cases[i].chain) begin
                while (exp_q.size() != 0) @(posedge clk);
                write_set(1'b0, cases[i].dc);
                write_set(1'b1, cases[i].ac);
            end
            @(posedge clk);
            in_valid_i <= 1'b1;
            resid_i    <= cases[i].resid;
            exp_q.push_back(model_block(cases[i].resid, cases[i].dc, cases[i].ac));
            if (i == n_case - 1 || !cases[i+1].chain) begin
                @(posedge clk);
                in_valid_i <= 1'b0;
            end
        end

        while (exp_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);
        if (stamp_q.size() == 0 &&
            residual_coder_inst.residual_coder_chk_inst.err_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Strobes remained without a matching output or an assertion failed");
            $display("*** FAILED ***");
            $fatal(1, "run ended with errors");
        end
    end

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(posedge clk) begin
        expect_t e;
        longint  t0;
        cyc = cyc + 1;
        if (in_valid_i)
            stamp_q.push_back(cyc);
        if (residual_coder_inst.residual_coder_chk_inst.err_cnt != 0) begin
            $display("A bound assertion on residual_coder failed before %0t ns", $time);
            $display("*** FAILED ***");
            $fatal(1, "assertion failed");
        end else if (out_valid_o) begin
            if (exp_q.size() == 0 || stamp_q.size() == 0) begin
                $display("Output appeared at %0t ns with no block outstanding", $time);
                $display("*** FAILED ***");
                $fatal(1, "unexpected output");
            end else begin
                e  = exp_q.pop_front();
                t0 = stamp_q.pop_front();
                compare_value("latency", cyc - t0, latency);
                for (int k = 0; k < 16; k++) begin
                    compare_value($sformatf("levels_o[%0d]", k),
                                  $signed(levels_o[k]), $signed(e.levels[k]));
                    compare_value($sformatf("dq_o[%0d]", k),
                                  $signed(dq_o[k]), $signed(e.dq[k]));
                end
                compare_value("nz_o", nz_o, e.nz);
            end
        end
    end

    // Watchdog sized from the case count
    initial begin
        #((n_case * 20 + 100) * 10);
        $display("Timeout, outputs stopped arriving within %0d cycles", n_case * 20 + 100);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule
